/* filelist.f */
rtl/game_pkg.sv
rtl/display_pkg.sv
rtl/game_status_if.sv
rtl/button_sync.sv
rtl/lfsr_random.sv
rtl/game_ctrl.sv
rtl/display_drive.sv
rtl/memory_game_top.sv
test/tb_memory_game.sv

/* test/tb_memory_game.sv */
module tb_memory_game;
    timeunit 1ns;
    timeprecision 100ps;

    import game_pkg::*;
    import display_pkg::*;

    localparam int DEBOUNCE_CYCLES = 4;
    localparam int TICK_CYCLES     = 20;
    localparam int COUNT_SECONDS   = 3;
    localparam int BEEP_CYCLES     = 6;
    localparam int SCAN_CYCLES     = 3;
    localparam int STEP_LIMIT      = COUNT_SECONDS * TICK_CYCLES + 60;
    localparam int WATCHDOG_CYCLES = LEVEL_COUNT * 2 * STEP_LIMIT + 200;

    logic        clk;
    logic        sw;
    logic        enable;
    logic        go;
    logic        start;
    logic [6:0]  dip;
    logic [15:0] led;
    seg_t        seg;
    dig_t        dig;
    logic        beep;

    // history of the outputs and what the stimulus is doing
    logic [15:0] led_prev       = '0;
    logic [1:0]  enable_hist    = '0;
    logic        beep_prev      = 1'b0;
    int          judge_count    = 0;
    logic        countdown_zero = 1'b1;
    logic [6:0]  target_rec     = '0;
    logic        early_phase    = 1'b0;
    logic        entry_phase    = 1'b0;
    logic        entry_ok       = 1'b0;
    integer      seed           = 32'he1f4_a91e;

    memory_game_top #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .TICK_CYCLES     (TICK_CYCLES),
        .COUNT_SECONDS   (COUNT_SECONDS),
        .BEEP_CYCLES     (BEEP_CYCLES),
        .SCAN_CYCLES     (SCAN_CYCLES)
    ) dut_i (
        .clk    (clk),
        .sw     (sw),
        .enable (enable),
        .go     (go),
        .start  (start),
        .dip    (dip),
        .led    (led),
        .seg    (seg),
        .dig    (dig),
        .beep   (beep)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    function automatic int level_of_leds(input logic [2:0] bits);
        if (bits[2])
            return 3;
        if (bits[1])
            return 2;
        return 1;
    endfunction

    // level n holds a target of 4+n bits
    function automatic logic [6:0] width_mask(input logic [2:0] bits);
        case (level_of_leds(bits))
            1: return 7'h1f;
            2: return 7'h3f;
            default: return 7'h7f;
        endcase
    endfunction

    always @(posedge clk)
    begin
        led_prev    <= led;
        enable_hist <= {enable_hist[0], enable};
        beep_prev   <= beep;
        if (beep && !beep_prev)
            judge_count <= judge_count + 1;
        // digit 1 carries the countdown
        if (dig == 8'hfd)
            countdown_zero <= (seg == SEG_CODES[0]);
    end

    idle_outputs: assert property (@(posedge clk)
        (sw || (!enable && enable_hist == 2'b00)) |-> led == '0 && !beep && dig == '1)
        else fail_run($sformatf("mismatch led/beep/dig: got %h %h %h, expected 0000 0 ff",
            $sampled(led), $sampled(beep), $sampled(dig)));

    one_digit: assert property (@(posedge clk) disable iff (sw)
        enable |-> $countones(~dig) <= 1)
        else fail_run($sformatf("mismatch dig: got %h, more than one digit low", $sampled(dig)));

    level_digit: assert property (@(posedge clk) disable iff (sw)
        enable && dig == 8'hfe && $onehot(led[15:13])
        |-> seg == SEG_CODES[level_of_leds(led[15:13])])
        else fail_run($sformatf("mismatch seg: got %h, expected %h", $sampled(seg),
            SEG_CODES[level_of_leds($sampled(led[15:13]))]));

    early_start_ignored: assert property (@(posedge clk) disable iff (sw)
        early_phase |-> !beep && led[15:13] == led_prev[15:13] && led[6:0] == target_rec)
        else fail_run($sformatf("mismatch led/beep: got %h %h, expected %h with target %h, 0",
            $sampled(led), $sampled(beep), $sampled(led_prev[15:13]), $sampled(target_rec)));

    blank_after_countdown: assert property (@(posedge clk) disable iff (sw)
        entry_phase |-> led[6:0] == '0)
        else fail_run($sformatf("mismatch led[6:0]: got %h, expected 00", $sampled(led[6:0])));

    // judgement seen at the first beep cycle, new level one cycle later
    level_steps_up: assert property (@(posedge clk) disable iff (sw)
        $rose(beep) && entry_ok && !led[15]
        |=> led[15:13] == {led_prev[14:13], 1'b0}
            && (led[6:0] & ~width_mask(led[15:13])) == '0)
        else fail_run($sformatf("mismatch led: got %h, expected level bits %h, target mask %h",
            $sampled(led), {$sampled(led_prev[14:13]), 1'b0},
            width_mask({$sampled(led_prev[14:13]), 1'b0})));

    wrong_entry_retries: assert property (@(posedge clk) disable iff (sw)
        $rose(beep) && !entry_ok
        |=> led[15:13] == led_prev[15:13] && led[6:0] == target_rec)
        else fail_run($sformatf("mismatch led: got %h, expected level bits %h, target %h",
            $sampled(led), $sampled(led_prev[15:13]), $sampled(target_rec)));

    last_level_wins: assert property (@(posedge clk) disable iff (sw)
        $rose(beep) && entry_ok && led[15] |=> led == '1)
        else fail_run($sformatf("mismatch led: got %h, expected ffff", $sampled(led)));

    beep_length: assert property (@(posedge clk) disable iff (sw)
        $rose(beep) |-> beep [*BEEP_CYCLES] ##1 !beep)
        else fail_run("beep did not last exactly the beep time");

    victory_restart: assert property (@(posedge clk) disable iff (sw)
        led_prev == '1 && led != '1 && enable |-> led[15:13] == 3'b001)
        else fail_run($sformatf("mismatch led[15:13]: got %h, expected 1", $sampled(led[15:13])));

    task automatic drive_button(input bit use_start, input logic level);
        if (use_start)
            start <= level;
        else
            go <= level;
    endtask

    // bouncy contact, then a clean hold, then release
    task automatic press_button(input bit use_start);
        int bits;
        repeat (4)
        begin
            @(posedge clk);
            bits = $random(seed);
            drive_button(use_start, bits[0]);
        end
        repeat (10)
        begin
            @(posedge clk);
            drive_button(use_start, 1'b1);
        end
        @(posedge clk);
        drive_button(use_start, 1'b0);
    endtask

    task automatic wait_countdown(input bit want_zero);
        int cycles;
        cycles = 0;
        while (countdown_zero != want_zero)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > STEP_LIMIT)
                fail_run("timeout waiting for the countdown digit");
        end
    endtask

    task automatic wait_judgement(input int count_before);
        int cycles;
        cycles = 0;
        while (judge_count == count_before || beep)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > STEP_LIMIT)
                fail_run("timeout waiting for the judgement beep");
        end
    endtask

    task automatic wait_level_one();
        int cycles;
        cycles = 0;
        while (led[15:13] != 3'b001)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > STEP_LIMIT)
                fail_run("timeout waiting for the restart at level 1");
        end
    endtask

    task automatic play_attempt(input bit correct, input bit early);
        int count_before;
        wait_countdown(1'b0);
        target_rec <= led[6:0];
        if (early)
        begin
            // start while counting must be ignored
            early_phase <= 1'b1;
            dip         <= led[6:0];
            press_button(1'b1);
            repeat (DEBOUNCE_CYCLES + 4)
                @(posedge clk);
            early_phase <= 1'b0;
        end
        wait_countdown(1'b1);
        entry_phase <= 1'b1;
        repeat (2)
            @(posedge clk);
        entry_phase <= 1'b0;
        entry_ok    <= correct;
        dip         <= correct ? target_rec : target_rec ^ 7'h01;
        count_before = judge_count;
        press_button(1'b1);
        wait_judgement(count_before);
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES)
            @(posedge clk);
        fail_run("watchdog expired before the test finished");
    end

    initial
    begin
        int level;
        sw     <= 1'b1;
        enable <= 1'b0;
        go     <= 1'b0;
        start  <= 1'b0;
        dip    <= '0;
        repeat (3)
            @(posedge clk);
        sw <= 1'b0;
        // go with the power switch off
        press_button(1'b0);
        repeat (DEBOUNCE_CYCLES + 4)
            @(posedge clk);
        enable <= 1'b1;
        repeat (4)
            @(posedge clk);
        press_button(1'b0);
        for (level = 1; level <= LEVEL_COUNT; level++)
        begin
            play_attempt(1'b0, level == 1);
            play_attempt(1'b1, 1'b0);
        end
        // restart from victory, then power off
        press_button(1'b0);
        wait_level_one();
        enable <= 1'b0;
        repeat (8)
            @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

/* rtl/memory_game_top.sv */
module memory_game_top #(
    parameter int          DEBOUNCE_CYCLES = 500_000,
    parameter int          TICK_CYCLES     = 50_000_000,
    parameter int          COUNT_SECONDS   = 5,
    parameter int          BEEP_CYCLES     = 25_000_000,
    parameter int          SCAN_CYCLES     = 50_000,
    parameter logic [15:0] LFSR_SEED       = 16'hace1
) (
    input  logic               clk,
    input  logic               sw,
    input  logic               enable,
    input  logic               go,
    input  logic               start,
    input  logic [6:0]         dip,
    output logic [15:0]        led,
    output display_pkg::seg_t  seg,
    output display_pkg::dig_t  dig,
    output logic               beep
);
    import game_pkg::*;

    logic    go_pulse;
    logic    start_pulse;
    logic    random_next;
    target_t random_value;

    game_status_if status_if ();

    // button conditioning
    button_sync #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) go_sync_i (
        .clk   (clk),
        .sw    (sw),
        .raw   (go),
        .pulse (go_pulse)
    );

    button_sync #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) start_sync_i (
        .clk   (clk),
        .sw    (sw),
        .raw   (start),
        .pulse (start_pulse)
    );

    lfsr_random #(.LFSR_SEED(LFSR_SEED)) random_i (
        .clk   (clk),
        .sw    (sw),
        .next  (random_next),
        .value (random_value)
    );

    // game control
    game_ctrl #(
        .TICK_CYCLES   (TICK_CYCLES),
        .COUNT_SECONDS (COUNT_SECONDS)
    ) ctrl_i (
        .clk         (clk),
        .sw          (sw),
        .enable      (enable),
        .go_pulse    (go_pulse),
        .start_pulse (start_pulse),
        .dip         (dip),
        .random      (random_value),
        .random_next (random_next),
        .status      (status_if)
    );

    // display driving
    display_drive #(
        .BEEP_CYCLES (BEEP_CYCLES),
        .SCAN_CYCLES (SCAN_CYCLES)
    ) disp_i (
        .clk    (clk),
        .sw     (sw),
        .status (status_if),
        .led    (led),
        .seg    (seg),
        .dig    (dig),
        .beep   (beep)
    );

endmodule

/* rtl/display_drive.sv */
module display_drive #(
    parameter int BEEP_CYCLES = 25_000_000,
    parameter int SCAN_CYCLES = 50_000
) (
    input  logic               clk,
    input  logic               sw,
    game_status_if.disp        status,
    output logic [15:0]        led,
    output display_pkg::seg_t  seg,
    output display_pkg::dig_t  dig,
    output logic               beep
);
    import game_pkg::*;
    import display_pkg::*;

    localparam int SCAN_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;
    localparam int BEEP_W = $clog2(BEEP_CYCLES + 1);

    logic [15:0]       led_d;
    logic [SCAN_W-1:0] scan_q;
    logic              digit_sel_q;
    logic [BEEP_W-1:0] beep_q;
    seg_t              seconds_code;

    // level bits on led[15:13], target on the low bits while counting
    always_comb
    begin
        led_d = '0;
        case (status.state)
            GREET:
                led_d[15:13] = 3'b111;
            PLAY, JUDGE:
            begin
                led_d[12 + status.level] = 1'b1;
                if (status.state == PLAY && status.seconds_left != '0)
                    led_d[6:0] = status.target & level_mask(status.level);
            end
            VICTORY:
                led_d = '1;
            default:
                led_d = '0;
        endcase
    end

    // no digit glyph above 9
    assign seconds_code = (status.seconds_left <= seconds_t'(9)) ?
                          SEG_CODES[status.seconds_left] : SEG_BLANK;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            led         <= '0;
            scan_q      <= '0;
            digit_sel_q <= 1'b0;
            seg         <= SEG_BLANK;
            dig         <= '1;
            beep_q      <= '0;
        end
        else
        begin
            led <= led_d;

            if (scan_q == SCAN_W'(SCAN_CYCLES - 1))
            begin
                scan_q      <= '0;
                digit_sel_q <= ~digit_sel_q;
            end
            else
            begin
                scan_q <= scan_q + 1'b1;
            end

            if (status.state == IDLE)
            begin
                dig <= '1;
                seg <= SEG_BLANK;
            end
            else if (!digit_sel_q)
            begin
                // digit 0 shows the level
                dig <= 8'hfe;
                seg <= SEG_CODES[status.level];
            end
            else
            begin
                dig <= 8'hfd;
                seg <= seconds_code;
            end

            // beeper runs for BEEP_CYCLES after each judgement
            if (status.judged)
                beep_q <= BEEP_W'(BEEP_CYCLES);
            else if (beep_q != '0)
                beep_q <= beep_q - 1'b1;
        end
    end

    assign beep = (beep_q != '0);

    one_digit_lit: assert property (@(posedge clk) disable iff (sw) $countones(~dig) <= 1)
        else $error("display_drive: more than one digit selected");

endmodule

/* rtl/game_ctrl.sv */
module game_ctrl #(
    parameter int TICK_CYCLES   = 50_000_000,
    parameter int COUNT_SECONDS = 5
) (
    input  logic               clk,
    input  logic               sw,
    input  logic               enable,
    input  logic               go_pulse,
    input  logic               start_pulse,
    input  game_pkg::target_t  dip,
    input  game_pkg::target_t  random,
    output logic               random_next,
    game_status_if.ctrl        status
);
    import game_pkg::*;

    localparam int TICK_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

    game_state_e       state_q;
    game_state_e       state_d;
    level_t            level_q;
    level_t            level_d;
    seconds_t          seconds_q;
    logic [TICK_W-1:0] tick_q;
    logic              reload;
    logic              match;

    // the random value register doubles as the held target
    assign match = ((dip ^ random) & level_mask(level_q)) == '0;

    always_comb
    begin
        state_d     = state_q;
        level_d     = level_q;
        random_next = 1'b0;
        reload      = 1'b0;
        if (!enable)
        begin
            state_d = IDLE;
            level_d = level_t'(1);
        end
        else
        begin
            case (state_q)
                IDLE:
                    state_d = GREET;
                GREET, PLAY, VICTORY:
                begin
                    if (go_pulse)
                    begin
                        // restart at level 1 with a fresh target
                        state_d     = PLAY;
                        level_d     = level_t'(1);
                        random_next = 1'b1;
                        reload      = 1'b1;
                    end
                    else if (state_q == PLAY && start_pulse && seconds_q == '0)
                    begin
                        state_d = JUDGE;
                    end
                end
                JUDGE:
                begin
                    if (match && level_q == level_t'(LEVEL_COUNT))
                    begin
                        state_d = VICTORY;
                    end
                    else
                    begin
                        // retry keeps level and target, countdown restarts
                        state_d = PLAY;
                        reload  = 1'b1;
                        if (match)
                        begin
                            level_d     = level_q + 2'd1;
                            random_next = 1'b1;
                        end
                    end
                end
                default:
                    state_d = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            state_q   <= IDLE;
            level_q   <= level_t'(1);
            seconds_q <= '0;
            tick_q    <= '0;
        end
        else
        begin
            state_q <= state_d;
            level_q <= level_d;
            if (reload)
            begin
                seconds_q <= seconds_t'(COUNT_SECONDS);
                tick_q    <= '0;
            end
            else if (state_q == PLAY && seconds_q != '0)
            begin
                // one second per TICK_CYCLES cycles
                if (tick_q == TICK_W'(TICK_CYCLES - 1))
                begin
                    tick_q    <= '0;
                    seconds_q <= seconds_q - 1'b1;
                end
                else
                begin
                    tick_q <= tick_q + 1'b1;
                end
            end
            else if (state_q != PLAY)
            begin
                seconds_q <= '0;
                tick_q    <= '0;
            end
        end
    end

    assign status.state        = state_q;
    assign status.level        = level_q;
    assign status.target       = random;
    assign status.seconds_left = seconds_q;
    assign status.judged       = (state_q == JUDGE);

    judge_after_countdown: assert property (@(posedge clk) disable iff (sw)
        (state_q == PLAY) ##1 (state_q == JUDGE) |-> $past(seconds_q) == '0)
        else $error("game_ctrl: JUDGE entered while the countdown ran");

    level_in_range: assert property (@(posedge clk) disable iff (sw)
        level_q >= level_t'(1) && level_q <= level_t'(LEVEL_COUNT))
        else $error("game_ctrl: level out of range");

endmodule

/* rtl/lfsr_random.sv */
module lfsr_random #(
    parameter logic [15:0] LFSR_SEED = 16'hace1
) (
    input  logic               clk,
    input  logic               sw,
    input  logic               next,
    output game_pkg::target_t  value
);

    logic [15:0] lfsr_q;

    // galois form of x^16 + x^14 + x^13 + x^11 + 1, steps every cycle
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            lfsr_q <= LFSR_SEED;
            value  <= '0;
        end
        else
        begin
            lfsr_q <= (lfsr_q >> 1) ^ (lfsr_q[0] ? 16'hb400 : 16'h0000);
            // target holds until the next request
            if (next)
                value <= lfsr_q[6:0];
        end
    end

    lfsr_never_zero: assert property (@(posedge clk) disable iff (sw) lfsr_q != '0)
        else $error("lfsr_random: register reached zero");

endmodule

/* rtl/button_sync.sv */
module button_sync #(
    parameter int DEBOUNCE_CYCLES = 500_000
) (
    input  logic clk,
    input  logic sw,
    input  logic raw,
    output logic pulse
);

    localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

    logic [1:0]       sync_q;
    logic             stable_q;
    logic [CNT_W-1:0] cnt_q;
    logic             settled;

    // new level has held long enough
    assign settled = (sync_q[1] != stable_q) && (cnt_q == CNT_W'(DEBOUNCE_CYCLES - 1));

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            sync_q   <= '0;
            stable_q <= 1'b0;
            cnt_q    <= '0;
            pulse    <= 1'b0;
        end
        else
        begin
            sync_q <= {sync_q[0], raw};
            pulse  <= 1'b0;
            if (sync_q[1] == stable_q)
            begin
                cnt_q <= '0;
            end
            else if (settled)
            begin
                cnt_q    <= '0;
                stable_q <= sync_q[1];
                // rising edge of the clean level only
                pulse    <= sync_q[1];
            end
            else
            begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    single_cycle_pulse: assert property (@(posedge clk) disable iff (sw) pulse |=> !pulse)
        else $error("button_sync: pulse high on two consecutive cycles");

endmodule

/* rtl/game_status_if.sv */
interface game_status_if;
    import game_pkg::*;

    level_t      level;
    game_state_e state;
    target_t     target;
    seconds_t    seconds_left;
    // one cycle per judgement
    logic        judged;

    modport ctrl (
        output level,
        output state,
        output target,
        output seconds_left,
        output judged
    );

    modport disp (
        input level,
        input state,
        input target,
        input seconds_left,
        input judged
    );

endinterface

/* rtl/display_pkg.sv */
package display_pkg;

    // segments a..g on bits 0..6, decimal point on bit 7, all active low
    typedef logic [7:0] seg_t;

    // one select per digit, active low
    typedef logic [7:0] dig_t;

    // unlit digit
    localparam seg_t SEG_BLANK = 8'hff;

    // digits 0 to 9
    localparam seg_t SEG_CODES [10] = '{
        8'hc0,
        8'hf9,
        8'ha4,
        8'hb0,
        8'h99,
        8'h92,
        8'h82,
        8'hf8,
        8'h80,
        8'h90
    };

endpackage

/* rtl/game_pkg.sv */
package game_pkg;

    // three levels, each one bit wider than the last
    localparam int LEVEL_COUNT = 3;
    localparam int TARGET_W = 7;
    localparam int SECONDS_W = 4;

    // current level, 1 to LEVEL_COUNT
    typedef logic [1:0] level_t;

    // random target and player entry
    typedef logic [TARGET_W-1:0] target_t;

    // seconds left on the countdown
    typedef logic [SECONDS_W-1:0] seconds_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        GREET,
        PLAY,
        JUDGE,
        VICTORY
    } game_state_e;

    // level n compares the low 4+n bits
    function automatic target_t level_mask(level_t level);
        return target_t'((1 << (4 + level)) - 1);
    endfunction

endpackage
